// File: hw/cpu_axi_pkg.sv
package cpu_axi_pkg;

    localparam int AXI_ADDR_WIDTH = 32;
    localparam int AXI_DATA_WIDTH = 32;
    localparam int AXI_STRB_WIDTH = 4;
    localparam int AXI_ID_WIDTH   = 4;
    localparam int AXI_XID_WIDTH  = 5;     // manager id plus source bit

    localparam int MEM_WORDS      = 1024;
    localparam int MEM_IDX_WIDTH  = 10;

    localparam logic SRC_IF = 1'b0;
    localparam logic SRC_LS = 1'b1;

    typedef logic [AXI_ADDR_WIDTH-1:0] axi_addr_t;
    typedef logic [AXI_DATA_WIDTH-1:0] axi_data_t;
    typedef logic [AXI_STRB_WIDTH-1:0] axi_strb_t;
    typedef logic [AXI_ID_WIDTH-1:0]   axi_id_t;
    typedef logic [AXI_XID_WIDTH-1:0]  axi_xid_t;
    typedef logic [7:0]                axi_len_t;    // beats minus one
    typedef logic [1:0]                axi_resp_t;
    typedef logic [MEM_IDX_WIDTH-1:0]  mem_idx_t;

    localparam axi_resp_t  RESP_OKAY  = 2'b00;
    localparam logic [1:0] BURST_INCR = 2'b01;

    typedef enum logic {
        RD_IDLE,
        RD_BURST
    } rd_state_e;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_DATA,
        WR_RESP
    } wr_state_e;

endpackage

// File: hw/axi_crossbar.sv
`timescale 1ns/1ps

module axi_crossbar
    import cpu_axi_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    // if port, source 0
    input  logic       if_axi_ar_valid_i,
    output logic       if_axi_ar_ready_o,
    input  axi_addr_t  if_axi_ar_addr_i,
    input  axi_id_t    if_axi_ar_id_i,
    input  axi_len_t   if_axi_ar_len_i,
    input  logic [1:0] if_axi_ar_burst_i,
    output logic       if_axi_r_valid_o,
    input  logic       if_axi_r_ready_i,
    output axi_data_t  if_axi_r_data_o,
    output axi_resp_t  if_axi_r_resp_o,
    output logic       if_axi_r_last_o,
    output axi_id_t    if_axi_r_id_o,
    // ls port, source 1
    input  logic       ls_axi_ar_valid_i,
    output logic       ls_axi_ar_ready_o,
    input  axi_addr_t  ls_axi_ar_addr_i,
    input  axi_id_t    ls_axi_ar_id_i,
    input  axi_len_t   ls_axi_ar_len_i,
    input  logic [1:0] ls_axi_ar_burst_i,
    output logic       ls_axi_r_valid_o,
    input  logic       ls_axi_r_ready_i,
    output axi_data_t  ls_axi_r_data_o,
    output axi_resp_t  ls_axi_r_resp_o,
    output logic       ls_axi_r_last_o,
    output axi_id_t    ls_axi_r_id_o,
    input  logic       ls_axi_aw_valid_i,
    output logic       ls_axi_aw_ready_o,
    input  axi_addr_t  ls_axi_aw_addr_i,
    input  axi_id_t    ls_axi_aw_id_i,
    input  axi_len_t   ls_axi_aw_len_i,
    input  logic [1:0] ls_axi_aw_burst_i,
    input  logic       ls_axi_w_valid_i,
    output logic       ls_axi_w_ready_o,
    input  axi_data_t  ls_axi_w_data_i,
    input  axi_strb_t  ls_axi_w_strb_i,
    input  logic       ls_axi_w_last_i,
    output logic       ls_axi_b_valid_o,
    input  logic       ls_axi_b_ready_i,
    output axi_resp_t  ls_axi_b_resp_o,
    output axi_id_t    ls_axi_b_id_o,
    // memory side
    output logic       axi_aw_valid_o,
    input  logic       axi_aw_ready_i,
    output axi_addr_t  axi_aw_addr_o,
    output axi_xid_t   axi_aw_id_o,
    output axi_len_t   axi_aw_len_o,
    output logic [1:0] axi_aw_burst_o,
    output logic       axi_w_valid_o,
    input  logic       axi_w_ready_i,
    output axi_data_t  axi_w_data_o,
    output axi_strb_t  axi_w_strb_o,
    output logic       axi_w_last_o,
    input  logic       axi_b_valid_i,
    output logic       axi_b_ready_o,
    input  axi_resp_t  axi_b_resp_i,
    input  axi_xid_t   axi_b_id_i,
    output logic       axi_ar_valid_o,
    input  logic       axi_ar_ready_i,
    output axi_addr_t  axi_ar_addr_o,
    output axi_xid_t   axi_ar_id_o,
    output axi_len_t   axi_ar_len_o,
    output logic [1:0] axi_ar_burst_o,
    input  logic       axi_r_valid_i,
    output logic       axi_r_ready_o,
    input  axi_data_t  axi_r_data_i,
    input  axi_resp_t  axi_r_resp_i,
    input  logic       axi_r_last_i,
    input  axi_xid_t   axi_r_id_i
);

    logic grant_q;      // ar pending, source locked
    logic grant_src_q;
    logic ar_src;
    logic ar_if;
    logic r_if;

    // if wins when the grant is free
    assign ar_src = grant_q ? grant_src_q : (if_axi_ar_valid_i ? SRC_IF : SRC_LS);
    assign ar_if  = (ar_src == SRC_IF);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            grant_q <= 1'b0;
        end else begin
            grant_q <= axi_ar_valid_o & ~axi_ar_ready_i;   // released on transfer
        end
    end

    always_ff @(posedge clk_i) begin
        grant_src_q <= ar_src;
    end

    assign axi_ar_valid_o    = ar_if ? if_axi_ar_valid_i : ls_axi_ar_valid_i;
    assign axi_ar_addr_o     = ar_if ? if_axi_ar_addr_i  : ls_axi_ar_addr_i;
    assign axi_ar_id_o       = {ar_src, (ar_if ? if_axi_ar_id_i : ls_axi_ar_id_i)};
    assign axi_ar_len_o      = ar_if ? if_axi_ar_len_i   : ls_axi_ar_len_i;
    assign axi_ar_burst_o    = ar_if ? if_axi_ar_burst_i : ls_axi_ar_burst_i;
    assign if_axi_ar_ready_o = axi_ar_ready_i & ar_if;
    assign ls_axi_ar_ready_o = axi_ar_ready_i & ~ar_if;

    // r beats go back by the source bit
    assign r_if             = (axi_r_id_i[AXI_XID_WIDTH-1] == SRC_IF);
    assign axi_r_ready_o    = r_if ? if_axi_r_ready_i : ls_axi_r_ready_i;
    assign if_axi_r_valid_o = axi_r_valid_i & r_if;
    assign ls_axi_r_valid_o = axi_r_valid_i & ~r_if;
    assign if_axi_r_data_o  = axi_r_data_i;
    assign ls_axi_r_data_o  = axi_r_data_i;
    assign if_axi_r_resp_o  = axi_r_resp_i;
    assign ls_axi_r_resp_o  = axi_r_resp_i;
    assign if_axi_r_last_o  = axi_r_last_i;
    assign ls_axi_r_last_o  = axi_r_last_i;
    assign if_axi_r_id_o    = axi_r_id_i[AXI_ID_WIDTH-1:0];
    assign ls_axi_r_id_o    = axi_r_id_i[AXI_ID_WIDTH-1:0];

    // writes only come from ls
    assign axi_aw_valid_o    = ls_axi_aw_valid_i;
    assign ls_axi_aw_ready_o = axi_aw_ready_i;
    assign axi_aw_addr_o     = ls_axi_aw_addr_i;
    assign axi_aw_id_o       = {SRC_LS, ls_axi_aw_id_i};
    assign axi_aw_len_o      = ls_axi_aw_len_i;
    assign axi_aw_burst_o    = ls_axi_aw_burst_i;
    assign axi_w_valid_o     = ls_axi_w_valid_i;
    assign ls_axi_w_ready_o  = axi_w_ready_i;
    assign axi_w_data_o      = ls_axi_w_data_i;
    assign axi_w_strb_o      = ls_axi_w_strb_i;
    assign axi_w_last_o      = ls_axi_w_last_i;
    assign ls_axi_b_valid_o  = axi_b_valid_i;
    assign axi_b_ready_o     = ls_axi_b_ready_i;
    assign ls_axi_b_resp_o   = axi_b_resp_i;
    assign ls_axi_b_id_o     = axi_b_id_i[AXI_ID_WIDTH-1:0];

endmodule

// File: hw/axi_mem_read.sv
`timescale 1ns/1ps

module axi_mem_read
    import cpu_axi_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      axi_ar_valid_i,
    output logic      axi_ar_ready_o,
    input  axi_addr_t axi_ar_addr_i,
    input  axi_xid_t  axi_ar_id_i,
    input  axi_len_t  axi_ar_len_i,
    output logic      axi_r_valid_o,
    input  logic      axi_r_ready_i,
    output axi_data_t axi_r_data_o,
    output axi_resp_t axi_r_resp_o,
    output logic      axi_r_last_o,
    output axi_xid_t  axi_r_id_o,
    output mem_idx_t  rd_idx_o,
    input  axi_data_t rd_data_i
);

    rd_state_e state_q;
    mem_idx_t  idx_q;
    axi_len_t  beat_q;
    axi_len_t  len_q;
    axi_xid_t  id_q;
    logic      ar_fire;
    logic      r_fire;

    assign ar_fire = axi_ar_valid_i & axi_ar_ready_o;
    assign r_fire  = axi_r_valid_o & axi_r_ready_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= RD_IDLE;
        end else begin
            case (state_q)
                RD_IDLE: begin
                    if (ar_fire) state_q <= RD_BURST;
                end
                RD_BURST: begin
                    if (r_fire && axi_r_last_o) state_q <= RD_IDLE;
                end
                default: state_q <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (ar_fire) begin
            idx_q  <= axi_ar_addr_i[MEM_IDX_WIDTH+1:2];  // word index
            beat_q <= '0;
            len_q  <= axi_ar_len_i;
            id_q   <= axi_ar_id_i;
        end else if (r_fire) begin
            idx_q  <= idx_q + 1'b1;     // wraps at depth
            beat_q <= beat_q + 1'b1;
        end
    end

    assign axi_ar_ready_o = (state_q == RD_IDLE);
    assign axi_r_valid_o  = (state_q == RD_BURST);
    assign axi_r_last_o   = (beat_q == len_q);
    assign axi_r_data_o   = rd_data_i;      // array read is async
    assign axi_r_resp_o   = RESP_OKAY;
    assign axi_r_id_o     = id_q;
    assign rd_idx_o       = idx_q;

endmodule

// File: hw/axi_mem_write.sv
`timescale 1ns/1ps

module axi_mem_write
    import cpu_axi_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      axi_aw_valid_i,
    output logic      axi_aw_ready_o,
    input  axi_addr_t axi_aw_addr_i,
    input  axi_xid_t  axi_aw_id_i,
    input  axi_len_t  axi_aw_len_i,
    input  logic      axi_w_valid_i,
    output logic      axi_w_ready_o,
    input  axi_data_t axi_w_data_i,
    input  axi_strb_t axi_w_strb_i,
    input  logic      axi_w_last_i,
    output logic      axi_b_valid_o,
    input  logic      axi_b_ready_i,
    output axi_resp_t axi_b_resp_o,
    output axi_xid_t  axi_b_id_o,
    output logic      wr_en_o,
    output mem_idx_t  wr_idx_o,
    output axi_data_t wr_data_o,
    output axi_strb_t wr_strb_o
);

    wr_state_e state_q;
    mem_idx_t  idx_q;
    axi_len_t  beat_q;
    axi_len_t  len_q;
    axi_xid_t  id_q;
    logic      aw_fire;
    logic      w_fire;
    logic      w_done;

    assign aw_fire = axi_aw_valid_i & axi_aw_ready_o;
    assign w_fire  = axi_w_valid_i & axi_w_ready_o;
    assign w_done  = axi_w_last_i | (beat_q == len_q);  // ends even if last is missing

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= WR_IDLE;
        end else begin
            case (state_q)
                WR_IDLE: begin
                    if (aw_fire) state_q <= WR_DATA;
                end
                WR_DATA: begin
                    if (w_fire && w_done) state_q <= WR_RESP;
                end
                WR_RESP: begin
                    if (axi_b_ready_i) state_q <= WR_IDLE;
                end
                default: state_q <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (aw_fire) begin
            idx_q  <= axi_aw_addr_i[MEM_IDX_WIDTH+1:2];
            beat_q <= '0;
            len_q  <= axi_aw_len_i;
            id_q   <= axi_aw_id_i;
        end else if (w_fire) begin
            idx_q  <= idx_q + 1'b1;
            beat_q <= beat_q + 1'b1;
        end
    end

    assign axi_aw_ready_o = (state_q == WR_IDLE);
    assign axi_w_ready_o  = (state_q == WR_DATA);
    assign axi_b_valid_o  = (state_q == WR_RESP);
    assign axi_b_resp_o   = RESP_OKAY;
    assign axi_b_id_o     = id_q;

    // one strobed word write per w beat
    assign wr_en_o   = w_fire;
    assign wr_idx_o  = idx_q;
    assign wr_data_o = axi_w_data_i;
    assign wr_strb_o = axi_w_strb_i;

endmodule

// File: hw/axi_mem.sv
`timescale 1ns/1ps

module axi_mem
    import cpu_axi_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       axi_aw_valid_i,
    output logic       axi_aw_ready_o,
    input  axi_addr_t  axi_aw_addr_i,
    input  axi_xid_t   axi_aw_id_i,
    input  axi_len_t   axi_aw_len_i,
    input  logic [1:0] axi_aw_burst_i,
    input  logic       axi_w_valid_i,
    output logic       axi_w_ready_o,
    input  axi_data_t  axi_w_data_i,
    input  axi_strb_t  axi_w_strb_i,
    input  logic       axi_w_last_i,
    output logic       axi_b_valid_o,
    input  logic       axi_b_ready_i,
    output axi_resp_t  axi_b_resp_o,
    output axi_xid_t   axi_b_id_o,
    input  logic       axi_ar_valid_i,
    output logic       axi_ar_ready_o,
    input  axi_addr_t  axi_ar_addr_i,
    input  axi_xid_t   axi_ar_id_i,
    input  axi_len_t   axi_ar_len_i,
    input  logic [1:0] axi_ar_burst_i,
    output logic       axi_r_valid_o,
    input  logic       axi_r_ready_i,
    output axi_data_t  axi_r_data_o,
    output axi_resp_t  axi_r_resp_o,
    output logic       axi_r_last_o,
    output axi_xid_t   axi_r_id_o
);

    axi_data_t mem_q [MEM_WORDS];
    mem_idx_t  rd_idx;
    mem_idx_t  wr_idx;
    axi_data_t wr_data;
    axi_strb_t wr_strb;
    logic      wr_en;
    axi_len_t  ar_len;
    axi_len_t  aw_len;

    // only INCR steps, anything else is one beat
    assign ar_len = (axi_ar_burst_i == BURST_INCR) ? axi_ar_len_i : '0;
    assign aw_len = (axi_aw_burst_i == BURST_INCR) ? axi_aw_len_i : '0;

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            for (int i = 0; i < AXI_STRB_WIDTH; i++) begin
                if (wr_strb[i]) mem_q[wr_idx][8*i +: 8] <= wr_data[8*i +: 8];
            end
        end
    end

    axi_mem_read u_axi_mem_read (
        .axi_ar_len_i (ar_len),
        .rd_idx_o     (rd_idx),
        .rd_data_i    (mem_q[rd_idx]),
        .*
    );

    axi_mem_write u_axi_mem_write (
        .axi_aw_len_i (aw_len),
        .wr_en_o      (wr_en),
        .wr_idx_o     (wr_idx),
        .wr_data_o    (wr_data),
        .wr_strb_o    (wr_strb),
        .*
    );

endmodule

// File: hw/cpu_mem_subsys.sv
`timescale 1ns/1ps

module cpu_mem_subsys
    import cpu_axi_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       if_axi_ar_valid_i,
    output logic       if_axi_ar_ready_o,
    input  axi_addr_t  if_axi_ar_addr_i,
    input  axi_id_t    if_axi_ar_id_i,
    input  axi_len_t   if_axi_ar_len_i,
    input  logic [1:0] if_axi_ar_burst_i,
    output logic       if_axi_r_valid_o,
    input  logic       if_axi_r_ready_i,
    output axi_data_t  if_axi_r_data_o,
    output axi_resp_t  if_axi_r_resp_o,
    output logic       if_axi_r_last_o,
    output axi_id_t    if_axi_r_id_o,
    input  logic       ls_axi_ar_valid_i,
    output logic       ls_axi_ar_ready_o,
    input  axi_addr_t  ls_axi_ar_addr_i,
    input  axi_id_t    ls_axi_ar_id_i,
    input  axi_len_t   ls_axi_ar_len_i,
    input  logic [1:0] ls_axi_ar_burst_i,
    output logic       ls_axi_r_valid_o,
    input  logic       ls_axi_r_ready_i,
    output axi_data_t  ls_axi_r_data_o,
    output axi_resp_t  ls_axi_r_resp_o,
    output logic       ls_axi_r_last_o,
    output axi_id_t    ls_axi_r_id_o,
    input  logic       ls_axi_aw_valid_i,
    output logic       ls_axi_aw_ready_o,
    input  axi_addr_t  ls_axi_aw_addr_i,
    input  axi_id_t    ls_axi_aw_id_i,
    input  axi_len_t   ls_axi_aw_len_i,
    input  logic [1:0] ls_axi_aw_burst_i,
    input  logic       ls_axi_w_valid_i,
    output logic       ls_axi_w_ready_o,
    input  axi_data_t  ls_axi_w_data_i,
    input  axi_strb_t  ls_axi_w_strb_i,
    input  logic       ls_axi_w_last_i,
    output logic       ls_axi_b_valid_o,
    input  logic       ls_axi_b_ready_i,
    output axi_resp_t  ls_axi_b_resp_o,
    output axi_id_t    ls_axi_b_id_o
);

    // crossbar to memory
    logic       axi_aw_valid, axi_aw_ready, axi_w_valid, axi_w_ready, axi_w_last;
    logic       axi_b_valid, axi_b_ready, axi_ar_valid, axi_ar_ready;
    logic       axi_r_valid, axi_r_ready, axi_r_last;
    logic [1:0] axi_aw_burst, axi_ar_burst;
    axi_addr_t  axi_aw_addr, axi_ar_addr;
    axi_xid_t   axi_aw_id, axi_b_id, axi_ar_id, axi_r_id;
    axi_len_t   axi_aw_len, axi_ar_len;
    axi_data_t  axi_w_data, axi_r_data;
    axi_strb_t  axi_w_strb;
    axi_resp_t  axi_b_resp, axi_r_resp;

    axi_crossbar u_axi_crossbar (
        .axi_aw_valid_o (axi_aw_valid),
        .axi_aw_ready_i (axi_aw_ready),
        .axi_aw_addr_o  (axi_aw_addr),
        .axi_aw_id_o    (axi_aw_id),
        .axi_aw_len_o   (axi_aw_len),
        .axi_aw_burst_o (axi_aw_burst),
        .axi_w_valid_o  (axi_w_valid),
        .axi_w_ready_i  (axi_w_ready),
        .axi_w_data_o   (axi_w_data),
        .axi_w_strb_o   (axi_w_strb),
        .axi_w_last_o   (axi_w_last),
        .axi_b_valid_i  (axi_b_valid),
        .axi_b_ready_o  (axi_b_ready),
        .axi_b_resp_i   (axi_b_resp),
        .axi_b_id_i     (axi_b_id),
        .axi_ar_valid_o (axi_ar_valid),
        .axi_ar_ready_i (axi_ar_ready),
        .axi_ar_addr_o  (axi_ar_addr),
        .axi_ar_id_o    (axi_ar_id),
        .axi_ar_len_o   (axi_ar_len),
        .axi_ar_burst_o (axi_ar_burst),
        .axi_r_valid_i  (axi_r_valid),
        .axi_r_ready_o  (axi_r_ready),
        .axi_r_data_i   (axi_r_data),
        .axi_r_resp_i   (axi_r_resp),
        .axi_r_last_i   (axi_r_last),
        .axi_r_id_i     (axi_r_id),
        .*
    );

    axi_mem u_axi_mem (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .axi_aw_valid_i (axi_aw_valid),
        .axi_aw_ready_o (axi_aw_ready),
        .axi_aw_addr_i  (axi_aw_addr),
        .axi_aw_id_i    (axi_aw_id),
        .axi_aw_len_i   (axi_aw_len),
        .axi_aw_burst_i (axi_aw_burst),
        .axi_w_valid_i  (axi_w_valid),
        .axi_w_ready_o  (axi_w_ready),
        .axi_w_data_i   (axi_w_data),
        .axi_w_strb_i   (axi_w_strb),
        .axi_w_last_i   (axi_w_last),
        .axi_b_valid_o  (axi_b_valid),
        .axi_b_ready_i  (axi_b_ready),
        .axi_b_resp_o   (axi_b_resp),
        .axi_b_id_o     (axi_b_id),
        .axi_ar_valid_i (axi_ar_valid),
        .axi_ar_ready_o (axi_ar_ready),
        .axi_ar_addr_i  (axi_ar_addr),
        .axi_ar_id_i    (axi_ar_id),
        .axi_ar_len_i   (axi_ar_len),
        .axi_ar_burst_i (axi_ar_burst),
        .axi_r_valid_o  (axi_r_valid),
        .axi_r_ready_i  (axi_r_ready),
        .axi_r_data_o   (axi_r_data),
        .axi_r_resp_o   (axi_r_resp),
        .axi_r_last_o   (axi_r_last),
        .axi_r_id_o     (axi_r_id)
    );

endmodule

// File: tb/tb_cpu_mem_subsys.sv
`timescale 1ns/1ps

module tb_cpu_mem_subsys
    import cpu_axi_pkg::*;
();

    localparam int N_ROUNDS        = 24;
    localparam int MAX_BEATS       = 8;
    localparam int MAX_GAP         = 4;     // ready mask forces one ready in four
    localparam int N_BURSTS        = MEM_WORDS / MAX_BEATS + 5 * N_ROUNDS;
    localparam int WATCHDOG_CYCLES = N_BURSTS * (MAX_BEATS * MAX_GAP + 16) + 200;

    typedef struct packed {
        axi_data_t data;
        axi_id_t   id;
        logic      last;
    } beat_t;

    logic       clk_i = 1'b0;
    logic       rst_i;
    logic       if_axi_ar_valid_i, if_axi_ar_ready_o;
    axi_addr_t  if_axi_ar_addr_i;
    axi_id_t    if_axi_ar_id_i;
    axi_len_t   if_axi_ar_len_i;
    logic [1:0] if_axi_ar_burst_i;
    logic       if_axi_r_valid_o, if_axi_r_ready_i, if_axi_r_last_o;
    axi_data_t  if_axi_r_data_o;
    axi_resp_t  if_axi_r_resp_o;
    axi_id_t    if_axi_r_id_o;
    logic       ls_axi_ar_valid_i, ls_axi_ar_ready_o;
    axi_addr_t  ls_axi_ar_addr_i;
    axi_id_t    ls_axi_ar_id_i;
    axi_len_t   ls_axi_ar_len_i;
    logic [1:0] ls_axi_ar_burst_i;
    logic       ls_axi_r_valid_o, ls_axi_r_ready_i, ls_axi_r_last_o;
    axi_data_t  ls_axi_r_data_o;
    axi_resp_t  ls_axi_r_resp_o;
    axi_id_t    ls_axi_r_id_o;
    logic       ls_axi_aw_valid_i, ls_axi_aw_ready_o;
    axi_addr_t  ls_axi_aw_addr_i;
    axi_id_t    ls_axi_aw_id_i;
    axi_len_t   ls_axi_aw_len_i;
    logic [1:0] ls_axi_aw_burst_i;
    logic       ls_axi_w_valid_i, ls_axi_w_ready_o, ls_axi_w_last_i;
    axi_data_t  ls_axi_w_data_i;
    axi_strb_t  ls_axi_w_strb_i;
    logic       ls_axi_b_valid_o, ls_axi_b_ready_i;
    axi_resp_t  ls_axi_b_resp_o;
    axi_id_t    ls_axi_b_id_o;

    integer    seed = 32'h66a3;
    int        errors = 0;
    string     test_name = "reset";
    axi_data_t ref_mem [int];       // word index to expected word
    beat_t     if_exp_q [$];
    beat_t     ls_exp_q [$];
    logic      held [2];
    axi_data_t held_data [2];
    logic      ls_quiet;
    time       if_ar_time, ls_ar_time;

    cpu_mem_subsys u_cpu_mem_subsys (.*);

    always #2 clk_i = ~clk_i;

    function automatic int word_idx(input axi_addr_t addr, input int k);
        return ((addr >> 2) + k) % MEM_WORDS;
    endfunction

    function automatic void ref_write(input int idx, input axi_data_t data, input axi_strb_t strb);
        axi_data_t word;
        int        b;
        word = ref_mem.exists(idx) ? ref_mem[idx] : 'x;
        for (b = 0; b < AXI_STRB_WIDTH; b++) begin
            if (strb[b]) word[8*b +: 8] = data[8*b +: 8];
        end
        ref_mem[idx] = word;
    endfunction

    function automatic void check_value(input string what, input logic [31:0] expected,
                                        input logic [31:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("Error %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endfunction

    function automatic void expect_burst(input logic src, input axi_addr_t addr,
                                         input axi_id_t id, input axi_len_t len);
        beat_t beat;
        int    k;
        for (k = 0; k <= len; k++) begin
            beat.data = ref_mem[word_idx(addr, k)];
            beat.id   = id;
            beat.last = (k == len);
            if (src == SRC_IF) if_exp_q.push_back(beat);
            else ls_exp_q.push_back(beat);
        end
    endfunction

    // one port's R channel, sampled at the rising edge
    function automatic void watch_r_port(input logic src, input logic valid, input logic ready,
                                         input axi_data_t data, input axi_id_t id,
                                         input logic last, input axi_resp_t resp);
        beat_t beat;
        logic  has_beat;
        string port;
        port = (src == SRC_IF) ? "if" : "ls";
        if (held[src]) begin
            check_value({port, " r_valid held"}, 1'b1, valid);
            check_value({port, " r_data held"}, held_data[src], data);
        end
        if (valid && ready) begin
            has_beat = 1'b0;
            if (src == SRC_IF && if_exp_q.size() > 0) begin
                beat     = if_exp_q.pop_front();
                has_beat = 1'b1;
            end
            if (src == SRC_LS && ls_exp_q.size() > 0) begin
                beat     = ls_exp_q.pop_front();
                has_beat = 1'b1;
            end
            assert (has_beat) else begin
                errors++;
                $display("The %s port returned an R beat that was never requested", port);
            end
            if (has_beat) begin
                check_value({port, " r_data"}, beat.data, data);
                check_value({port, " r_id"}, beat.id, id);
                check_value({port, " r_last"}, beat.last, last);
                check_value({port, " r_resp"}, RESP_OKAY, resp);
            end
        end
        held[src]      = valid && !ready;
        held_data[src] = data;
    endfunction

    always @(posedge clk_i) begin
        if (!rst_i) begin
            watch_r_port(SRC_IF, if_axi_r_valid_o, if_axi_r_ready_i, if_axi_r_data_o,
                         if_axi_r_id_o, if_axi_r_last_o, if_axi_r_resp_o);
            watch_r_port(SRC_LS, ls_axi_r_valid_o, ls_axi_r_ready_i, ls_axi_r_data_o,
                         ls_axi_r_id_o, ls_axi_r_last_o, ls_axi_r_resp_o);
            if (ls_quiet) check_value("ls r_valid during if read", 1'b0, ls_axi_r_valid_o);
            if (if_axi_ar_valid_i && if_axi_ar_ready_o) if_ar_time = $time;
            if (ls_axi_ar_valid_i && ls_axi_ar_ready_o) ls_ar_time = $time;
        end
    end

    task automatic ls_write_burst(input axi_addr_t addr, input axi_id_t id,
                                  input axi_len_t len, input logic full);
        axi_data_t data;
        axi_strb_t strb;
        int        k;
        @(negedge clk_i);
        ls_axi_aw_valid_i = 1'b1;
        ls_axi_aw_addr_i  = addr;
        ls_axi_aw_id_i    = id;
        ls_axi_aw_len_i   = len;
        ls_axi_aw_burst_i = BURST_INCR;
        do begin
            @(posedge clk_i);
        end while (!ls_axi_aw_ready_o);
        @(negedge clk_i);
        ls_axi_aw_valid_i = 1'b0;
        for (k = 0; k <= len; k++) begin
            data = $random(seed);
            strb = full ? 4'hf : axi_strb_t'($random(seed));
            ls_axi_w_valid_i = 1'b1;
            ls_axi_w_data_i  = data;
            ls_axi_w_strb_i  = strb;
            ls_axi_w_last_i  = (k == len);
            do begin
                @(posedge clk_i);
            end while (!ls_axi_w_ready_o);
            ref_write(word_idx(addr, k), data, strb);
            @(negedge clk_i);
        end
        ls_axi_w_valid_i = 1'b0;
        ls_axi_w_last_i  = 1'b0;
        ls_axi_b_ready_i = 1'b1;
        do begin
            @(posedge clk_i);
        end while (!ls_axi_b_valid_o);
        check_value("ls b_resp", RESP_OKAY, ls_axi_b_resp_o);
        check_value("ls b_id", id, ls_axi_b_id_o);
        @(negedge clk_i);
        ls_axi_b_ready_i = 1'b0;
    endtask

    // burst ends on the beat that carries r_last
    task automatic if_read_burst(input axi_addr_t addr, input axi_id_t id,
                                 input axi_len_t len, input logic [31:0] gaps);
        int   cyc;
        logic done;
        expect_burst(SRC_IF, addr, id, len);
        @(negedge clk_i);
        if_axi_ar_valid_i = 1'b1;
        if_axi_ar_addr_i  = addr;
        if_axi_ar_id_i    = id;
        if_axi_ar_len_i   = len;
        if_axi_ar_burst_i = BURST_INCR;
        do begin
            @(posedge clk_i);
        end while (!if_axi_ar_ready_o);
        @(negedge clk_i);
        if_axi_ar_valid_i = 1'b0;
        cyc  = 0;
        done = 1'b0;
        while (!done) begin
            if_axi_r_ready_i = gaps[cyc % 32];
            @(posedge clk_i);
            done = if_axi_r_valid_o && if_axi_r_ready_i && if_axi_r_last_o;
            cyc++;
            @(negedge clk_i);
        end
        if_axi_r_ready_i = 1'b0;
    endtask

    task automatic ls_read_burst(input axi_addr_t addr, input axi_id_t id,
                                 input axi_len_t len, input logic [31:0] gaps);
        int   cyc;
        logic done;
        expect_burst(SRC_LS, addr, id, len);
        @(negedge clk_i);
        ls_axi_ar_valid_i = 1'b1;
        ls_axi_ar_addr_i  = addr;
        ls_axi_ar_id_i    = id;
        ls_axi_ar_len_i   = len;
        ls_axi_ar_burst_i = BURST_INCR;
        do begin
            @(posedge clk_i);
        end while (!ls_axi_ar_ready_o);
        @(negedge clk_i);
        ls_axi_ar_valid_i = 1'b0;
        cyc  = 0;
        done = 1'b0;
        while (!done) begin
            ls_axi_r_ready_i = gaps[cyc % 32];
            @(posedge clk_i);
            done = ls_axi_r_valid_o && ls_axi_r_ready_i && ls_axi_r_last_o;
            cyc++;
            @(negedge clk_i);
        end
        ls_axi_r_ready_i = 1'b0;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        axi_addr_t   addr;
        axi_addr_t   addr2;
        axi_len_t    len;
        axi_len_t    len2;
        logic [31:0] gaps;
        logic [31:0] gaps2;
        int          n;
        rst_i             = 1'b1;
        if_axi_ar_valid_i = 1'b0;
        if_axi_ar_addr_i  = '0;
        if_axi_ar_id_i    = '0;
        if_axi_ar_len_i   = '0;
        if_axi_ar_burst_i = BURST_INCR;
        if_axi_r_ready_i  = 1'b0;
        ls_axi_ar_valid_i = 1'b0;
        ls_axi_ar_addr_i  = '0;
        ls_axi_ar_id_i    = '0;
        ls_axi_ar_len_i   = '0;
        ls_axi_ar_burst_i = BURST_INCR;
        ls_axi_r_ready_i  = 1'b0;
        ls_axi_aw_valid_i = 1'b0;
        ls_axi_aw_addr_i  = '0;
        ls_axi_aw_id_i    = '0;
        ls_axi_aw_len_i   = '0;
        ls_axi_aw_burst_i = BURST_INCR;
        ls_axi_w_valid_i  = 1'b0;
        ls_axi_w_data_i   = '0;
        ls_axi_w_strb_i   = '0;
        ls_axi_w_last_i   = 1'b0;
        ls_axi_b_ready_i  = 1'b0;
        held              = '{1'b0, 1'b0};
        held_data         = '{'0, '0};
        ls_quiet          = 1'b0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        @(posedge clk_i);
        check_value("if r_valid", 1'b0, if_axi_r_valid_o);
        check_value("ls r_valid", 1'b0, ls_axi_r_valid_o);
        check_value("ls b_valid", 1'b0, ls_axi_b_valid_o);

        // whole array gets known contents first
        test_name = "prefill";
        for (n = 0; n < MEM_WORDS / MAX_BEATS; n++) begin
            ls_write_burst(n * 4 * MAX_BEATS, axi_id_t'(n), 8'd7, 1'b1);
        end

        for (n = 0; n < N_ROUNDS; n++) begin
            addr  = $random(seed);
            addr[1:0] = 2'b00;
            len   = $random(seed) & 7;
            gaps  = $random(seed) | 32'h1111_1111;
            test_name = "ls write";
            ls_write_burst(addr, axi_id_t'($random(seed)), len, 1'b0);
            test_name = "ls read-back";
            ls_read_burst(addr, axi_id_t'($random(seed)), len, gaps);
            test_name = "if read";
            ls_quiet = 1'b1;
            if_read_burst(addr, axi_id_t'($random(seed)), len, 32'hffff_ffff);
            ls_quiet = 1'b0;

            // both ARs raised on the same edge
            addr2 = $random(seed);
            addr2[1:0] = 2'b00;
            len2  = $random(seed) & 7;
            gaps2 = $random(seed) | 32'h1111_1111;
            test_name = "concurrent reads";
            fork
                if_read_burst(addr, axi_id_t'(n), len, gaps);
                ls_read_burst(addr2, axi_id_t'(n + 5), len2, gaps2);
            join
            assert (if_ar_time < ls_ar_time) else begin
                errors++;
                $display("The if AR did not transfer before the ls AR in round %0d", n);
            end
        end

        assert (if_exp_q.size() == 0 && ls_exp_q.size() == 0) else begin
            errors++;
            $display("Some requested R beats never arrived");
        end
        $display("Run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
hw/cpu_axi_pkg.sv
hw/axi_crossbar.sv
hw/axi_mem_read.sv
hw/axi_mem_write.sv
hw/axi_mem.sv
hw/cpu_mem_subsys.sv
tb/tb_cpu_mem_subsys.sv

// File: Bender.yml
package:
  name: cpu_mem_subsys

sources:
  - hw/cpu_axi_pkg.sv
  - hw/axi_crossbar.sv
  - hw/axi_mem_read.sv
  - hw/axi_mem_write.sv
  - hw/axi_mem.sv
  - hw/cpu_mem_subsys.sv
  - target: test
    files:
      - tb/tb_cpu_mem_subsys.sv
